//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_exe_unit
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
LINTFLAGS ?= --lint-only --timing -Wall
PASS_TEXT ?= PASS: all tests

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_TEXT)" $(LOG) && echo "simulation passed" || \
		(echo "simulation failed"; exit 1)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- alu.sv
module alu (
    input  cpu_core_pkg::alu_op_t op,
    input  cpu_core_pkg::word_t   src1,
    input  cpu_core_pkg::word_t   src2,
    output cpu_core_pkg::word_t   result
);
    import cpu_core_pkg::*;

    logic        use_sub;
    word_t       adder_b;
    logic [32:0] adder_out;
    word_t       sum;
    logic        lt_signed;
    logic        lt_unsigned;
    logic [4:0]  shamt;

    // sub and both compares share the adder
    assign use_sub   = op[ALU_SUB] | op[ALU_SLT] | op[ALU_SLTU];
    assign adder_b   = use_sub ? ~src2 : src2;
    assign adder_out = {1'b0, src1} + {1'b0, adder_b} + {32'd0, use_sub};
    assign sum       = adder_out[31:0];

    assign lt_signed   = (src1[31] & ~src2[31]) | (~(src1[31] ^ src2[31]) & sum[31]);
    // no carry out of a - b means a < b
    assign lt_unsigned = ~adder_out[32];

    assign shamt = src2[4:0];

    assign result = ({32{op[ALU_ADD] | op[ALU_SUB]}} & sum)
                  | ({32{op[ALU_SLT]}}  & {31'd0, lt_signed})
                  | ({32{op[ALU_SLTU]}} & {31'd0, lt_unsigned})
                  | ({32{op[ALU_AND]}}  & (src1 & src2))
                  | ({32{op[ALU_OR]}}   & (src1 | src2))
                  | ({32{op[ALU_NOR]}}  & ~(src1 | src2))
                  | ({32{op[ALU_XOR]}}  & (src1 ^ src2))
                  | ({32{op[ALU_SLL]}}  & (src1 << shamt))
                  | ({32{op[ALU_SRL]}}  & (src1 >> shamt))
                  | ({32{op[ALU_SRA]}}  & word_t'($signed(src1) >>> shamt))
                  | ({32{op[ALU_LUI]}}  & src2);

endmodule

//--- cpu_core_pkg.sv
package cpu_core_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_idx_t;

    // one-hot, one bit per operation
    typedef logic [11:0] alu_op_t;

    localparam int ALU_ADD  = 0;
    localparam int ALU_SUB  = 1;
    localparam int ALU_SLT  = 2;
    localparam int ALU_SLTU = 3;
    localparam int ALU_AND  = 4;
    localparam int ALU_OR   = 5;
    localparam int ALU_NOR  = 6;
    localparam int ALU_XOR  = 7;
    localparam int ALU_SLL  = 8;
    localparam int ALU_SRL  = 9;
    localparam int ALU_SRA  = 10;
    localparam int ALU_LUI  = 11;

    typedef enum logic [1:0] {
        div_none,
        div_quot,
        div_rem
    } div_op_t;

    // one quotient bit per cycle
    localparam int DIV_STEPS = 32;

endpackage

//--- divider.sv
module divider (
    input logic clk,
    input logic reset,
    div_if.slave div
);
    import cpu_core_pkg::*;

    localparam int CNT_W = $clog2(DIV_STEPS);

    typedef enum logic [1:0] {idle, run, finish} div_state_t;

    div_state_t  state;
    logic [CNT_W-1:0] count;
    logic        last_step;
    logic        accept;
    word_t       rem_r;
    word_t       quo_r;
    word_t       divisor_r;
    word_t       dividend_r;
    logic        neg_quo;
    logic        neg_rem;
    logic        div_zero;
    logic [32:0] shifted;
    logic [32:0] diff;
    logic        step_ok;
    word_t       rem_next;
    word_t       quo_next;

    function automatic word_t magnitude(word_t v, logic sgn);
        return (sgn && v[31]) ? -v : v;
    endfunction

    assign accept    = div.start && (div.op != div_none);
    assign last_step = (state == run) && (count == CNT_W'(DIV_STEPS - 1));
    assign div.done  = (state == finish);

    // restoring step, quotient bits shift in from the right
    assign shifted  = {rem_r, quo_r[31]};
    assign diff     = shifted - {1'b0, divisor_r};
    assign step_ok  = ~diff[32];
    assign rem_next = step_ok ? diff[31:0] : shifted[31:0];
    assign quo_next = {quo_r[30:0], step_ok};

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= idle;
            count <= '0;
        end else if (accept) begin
            state <= run;
            count <= '0;
        end else if (state == run) begin
            count <= count + 1'b1;
            if (last_step) begin
                state <= finish;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            rem_r      <= '0;
            quo_r      <= magnitude(div.dividend, div.is_signed);
            divisor_r  <= magnitude(div.divisor, div.is_signed);
            dividend_r <= div.dividend;
            neg_quo    <= div.is_signed && (div.dividend[31] ^ div.divisor[31]);
            neg_rem    <= div.is_signed && div.dividend[31];
            div_zero   <= (div.divisor == '0);
        end else if (state == run) begin
            rem_r <= rem_next;
            quo_r <= quo_next;
        end

        // sign fix folded into the last step
        if (last_step) begin
            div.quotient  <= div_zero ? '1 : (neg_quo ? -quo_next : quo_next);
            div.remainder <= div_zero ? dividend_r : (neg_rem ? -rem_next : rem_next);
        end
    end

endmodule

//--- exe_intf.sv
interface div_if;
    import cpu_core_pkg::*;

    logic    start;
    logic    is_signed;
    div_op_t op;
    word_t   dividend;
    word_t   divisor;
    logic    done;
    word_t   quotient;
    word_t   remainder;

    modport master (
        output start, is_signed, op, dividend, divisor,
        input  done, quotient, remainder
    );

    modport slave (
        input  start, is_signed, op, dividend, divisor,
        output done, quotient, remainder
    );
endinterface

interface sram_req_if;
    import cpu_core_pkg::*;
    import mem_access_pkg::*;

    logic      req;
    logic      wr;
    wstrb_t    wstrb;
    mem_size_t size;
    word_t     addr;
    word_t     wdata;
    logic      addr_ok;

    modport master (output req, wr, wstrb, size, addr, wdata, input addr_ok);
    modport slave  (input req, wr, wstrb, size, addr, wdata, output addr_ok);
endinterface

//--- exe_stage.sv
module exe_stage (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    in_valid,
    output logic                    allowin,
    input  cpu_core_pkg::word_t     in_pc,
    input  cpu_core_pkg::word_t     in_imm,
    input  cpu_core_pkg::word_t     in_rj,
    input  cpu_core_pkg::word_t     in_rkd,
    input  cpu_core_pkg::alu_op_t   in_alu_op,
    input  logic                    in_src1_is_pc,
    input  logic                    in_src2_is_imm,
    input  logic                    in_src2_is_4,
    input  cpu_core_pkg::reg_idx_t  in_dest,
    input  logic                    in_gr_we,
    input  mem_access_pkg::mem_op_t in_mem_op,
    input  cpu_core_pkg::div_op_t   in_div_op,
    input  logic                    in_div_signed,
    input  logic                    ms_allowin,
    output logic                    out_valid,
    output cpu_core_pkg::word_t     out_pc,
    output cpu_core_pkg::word_t     out_result,
    output cpu_core_pkg::reg_idx_t  out_dest,
    output logic                    out_gr_we,
    output mem_access_pkg::mem_op_t out_mem_op,
    output logic [1:0]              out_addr_low,
    output logic                    fwd_valid,
    output cpu_core_pkg::reg_idx_t  fwd_dest,
    output cpu_core_pkg::word_t     fwd_result,
    output logic                    fwd_is_load,
    output cpu_core_pkg::alu_op_t   alu_op,
    output cpu_core_pkg::word_t     alu_src1,
    output cpu_core_pkg::word_t     alu_src2,
    input  cpu_core_pkg::word_t     alu_result,
    output logic                    mem_valid,
    output cpu_core_pkg::word_t     store_data,
    div_if.master                   div,
    input  logic                    addr_ok
);
    import cpu_core_pkg::*;
    import mem_access_pkg::*;

    logic     es_valid;
    logic     ready_go;
    logic     div_started;
    logic     is_div;
    logic     is_mem;
    word_t    pc_r;
    word_t    imm_r;
    word_t    rj_r;
    word_t    rkd_r;
    alu_op_t  alu_op_r;
    logic     src1_is_pc_r;
    logic     src2_is_imm_r;
    logic     src2_is_4_r;
    reg_idx_t dest_r;
    logic     gr_we_r;
    mem_op_t  mem_op_r;
    div_op_t  div_op_r;
    logic     div_signed_r;

    assign is_div = (div_op_r != div_none);
    assign is_mem = (mem_op_r != mem_none);

    always_comb begin
        if (is_div) begin
            ready_go = div_started && div.done;
        end else if (is_mem) begin
            // same condition that lets the request through
            ready_go = addr_ok && ms_allowin;
        end else begin
            ready_go = 1'b1;
        end
    end

    assign allowin   = !es_valid || (ready_go && ms_allowin);
    assign out_valid = es_valid && ready_go;
    assign mem_valid = es_valid;

    always_ff @(posedge clk) begin
        if (reset) begin
            es_valid <= 1'b0;
        end else if (allowin) begin
            es_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && allowin) begin
            pc_r          <= in_pc;
            imm_r         <= in_imm;
            rj_r          <= in_rj;
            rkd_r         <= in_rkd;
            alu_op_r      <= in_alu_op;
            src1_is_pc_r  <= in_src1_is_pc;
            src2_is_imm_r <= in_src2_is_imm;
            src2_is_4_r   <= in_src2_is_4;
            dest_r        <= in_dest;
            gr_we_r       <= in_gr_we;
            mem_op_r      <= in_mem_op;
            div_op_r      <= in_div_op;
            div_signed_r  <= in_div_signed;
        end
    end

    // one start per divide instruction
    always_ff @(posedge clk) begin
        if (reset) begin
            div_started <= 1'b0;
        end else if (div.start) begin
            div_started <= 1'b1;
        end else if (allowin) begin
            div_started <= 1'b0;
        end
    end

    assign div.start     = es_valid && is_div && !div_started;
    assign div.is_signed = div_signed_r;
    assign div.op        = div_op_r;
    assign div.dividend  = rj_r;
    assign div.divisor   = rkd_r;

    assign alu_op   = alu_op_r;
    assign alu_src1 = src1_is_pc_r ? pc_r : rj_r;
    assign alu_src2 = src2_is_4_r ? 32'd4 : (src2_is_imm_r ? imm_r : rkd_r);

    always_comb begin
        unique case (div_op_r)
            div_quot: out_result = div.quotient;
            div_rem:  out_result = div.remainder;
            default:  out_result = alu_result;
        endcase
    end

    assign out_pc       = pc_r;
    assign out_dest     = dest_r;
    assign out_gr_we    = gr_we_r;
    assign out_mem_op   = mem_op_r;
    assign out_addr_low = alu_result[1:0];
    assign store_data   = rkd_r;

    assign fwd_valid   = es_valid && gr_we_r;
    assign fwd_dest    = dest_r;
    assign fwd_result  = out_result;
    assign fwd_is_load = mem_op_r inside {ld_b, ld_bu, ld_h, ld_hu, ld_w};

endmodule

//--- exe_unit_asserts.sv
module exe_unit_asserts (
    input logic                clk,
    input logic                reset,
    input logic                out_valid,
    input logic                ms_allowin,
    input cpu_core_pkg::word_t out_result,
    input logic                data_sram_req,
    input logic                data_sram_wr
);
    timeunit 1ns;
    timeprecision 1ps;

    a_reset_clears_valid: assert property (@(posedge clk) reset |=> !out_valid)
        else $error("out_valid high in the cycle after reset");

    a_wr_needs_req: assert property (@(posedge clk) disable iff (reset)
        data_sram_wr |-> data_sram_req)
        else $error("data_sram_wr without data_sram_req");

    a_req_needs_allowin: assert property (@(posedge clk) disable iff (reset)
        data_sram_req |-> ms_allowin)
        else $error("data_sram_req while ms_allowin is low");

    // held result under back-pressure
    a_held_result: assert property (@(posedge clk) disable iff (reset)
        (out_valid && !ms_allowin) |=> $stable(out_result))
        else $error("out_result changed while held");

endmodule

bind exe_unit_top exe_unit_asserts u_asserts (.*);

//--- exe_unit_top.sv
module exe_unit_top (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      in_valid,
    output logic                      allowin,
    input  cpu_core_pkg::word_t       in_pc,
    input  cpu_core_pkg::word_t       in_imm,
    input  cpu_core_pkg::word_t       in_rj,
    input  cpu_core_pkg::word_t       in_rkd,
    input  cpu_core_pkg::alu_op_t     in_alu_op,
    input  logic                      in_src1_is_pc,
    input  logic                      in_src2_is_imm,
    input  logic                      in_src2_is_4,
    input  cpu_core_pkg::reg_idx_t    in_dest,
    input  logic                      in_gr_we,
    input  mem_access_pkg::mem_op_t   in_mem_op,
    input  cpu_core_pkg::div_op_t     in_div_op,
    input  logic                      in_div_signed,
    input  logic                      ms_allowin,
    output logic                      out_valid,
    output cpu_core_pkg::word_t       out_pc,
    output cpu_core_pkg::word_t       out_result,
    output cpu_core_pkg::reg_idx_t    out_dest,
    output logic                      out_gr_we,
    output mem_access_pkg::mem_op_t   out_mem_op,
    output logic [1:0]                out_addr_low,
    output logic                      fwd_valid,
    output cpu_core_pkg::reg_idx_t    fwd_dest,
    output cpu_core_pkg::word_t       fwd_result,
    output logic                      fwd_is_load,
    output logic                      data_sram_req,
    output logic                      data_sram_wr,
    output mem_access_pkg::wstrb_t    data_sram_wstrb,
    output mem_access_pkg::mem_size_t data_sram_size,
    output cpu_core_pkg::word_t       data_sram_addr,
    output cpu_core_pkg::word_t       data_sram_wdata,
    input  logic                      data_sram_addr_ok
);
    import cpu_core_pkg::*;

    alu_op_t alu_op;
    word_t   alu_src1;
    word_t   alu_src2;
    word_t   alu_result;
    logic    mem_valid;
    word_t   store_data;

    div_if      div_bus ();
    sram_req_if sram_bus ();

    exe_stage u_stage (
        .clk, .reset, .in_valid, .allowin,
        .in_pc, .in_imm, .in_rj, .in_rkd, .in_alu_op,
        .in_src1_is_pc, .in_src2_is_imm, .in_src2_is_4,
        .in_dest, .in_gr_we, .in_mem_op, .in_div_op, .in_div_signed,
        .ms_allowin, .out_valid, .out_pc, .out_result, .out_dest,
        .out_gr_we, .out_mem_op, .out_addr_low,
        .fwd_valid, .fwd_dest, .fwd_result, .fwd_is_load,
        .alu_op, .alu_src1, .alu_src2, .alu_result,
        .mem_valid, .store_data,
        .div     (div_bus.master),
        .addr_ok (sram_bus.addr_ok)
    );

    alu u_alu (
        .op     (alu_op),
        .src1   (alu_src1),
        .src2   (alu_src2),
        .result (alu_result)
    );

    divider u_divider (
        .clk,
        .reset,
        .div (div_bus.slave)
    );

    mem_request u_mem_request (
        .valid      (mem_valid),
        .ms_allowin (ms_allowin),
        .op         (out_mem_op),
        .addr       (alu_result),
        .store_data (store_data),
        .sram       (sram_bus.master)
    );

    assign sram_bus.addr_ok = data_sram_addr_ok;
    assign data_sram_req    = sram_bus.req;
    assign data_sram_wr     = sram_bus.wr;
    assign data_sram_wstrb  = sram_bus.wstrb;
    assign data_sram_size   = sram_bus.size;
    assign data_sram_addr   = sram_bus.addr;
    assign data_sram_wdata  = sram_bus.wdata;

endmodule

//--- mem_access_pkg.sv
package mem_access_pkg;

    typedef enum logic [3:0] {
        mem_none,
        ld_b,
        ld_bu,
        ld_h,
        ld_hu,
        ld_w,
        st_b,
        st_h,
        st_w
    } mem_op_t;

    typedef logic [3:0] wstrb_t;
    typedef logic [1:0] mem_size_t;

    localparam mem_size_t SIZE_BYTE = 2'd0;
    localparam mem_size_t SIZE_HALF = 2'd1;
    localparam mem_size_t SIZE_WORD = 2'd2;

endpackage

//--- mem_request.sv
module mem_request (
    input  logic                    valid,
    input  logic                    ms_allowin,
    input  mem_access_pkg::mem_op_t op,
    input  cpu_core_pkg::word_t     addr,
    input  cpu_core_pkg::word_t     store_data,
    sram_req_if.master              sram
);
    import cpu_core_pkg::*;
    import mem_access_pkg::*;

    always_comb begin
        sram.size  = SIZE_WORD;
        sram.wstrb = 4'b0000;
        sram.wdata = store_data;
        unique case (op)
            ld_b, ld_bu: sram.size = SIZE_BYTE;
            ld_h, ld_hu: sram.size = SIZE_HALF;
            st_b: begin
                sram.size  = SIZE_BYTE;
                sram.wstrb = wstrb_t'(4'b0001 << addr[1:0]);
                sram.wdata = {4{store_data[7:0]}};
            end
            st_h: begin
                sram.size  = SIZE_HALF;
                // odd offsets write nothing
                sram.wstrb = addr[0] ? 4'b0000 : (addr[1] ? 4'b1100 : 4'b0011);
                sram.wdata = {2{store_data[15:0]}};
            end
            st_w: sram.wstrb = 4'b1111;
            default: sram.size = SIZE_WORD;
        endcase
    end

    assign sram.req  = valid && ms_allowin && (op != mem_none);
    assign sram.wr   = sram.req && (|sram.wstrb);
    assign sram.addr = addr;

endmodule

//--- project.f
cpu_core_pkg.sv
mem_access_pkg.sv
exe_intf.sv
alu.sv
divider.sv
mem_request.sv
exe_stage.sv
exe_unit_top.sv
exe_unit_asserts.sv
tb_exe_unit.sv

//--- tb_exe_unit.sv
module tb_exe_unit;
    timeunit 1ns;
    timeprecision 1ps;

    import cpu_core_pkg::*;
    import mem_access_pkg::*;

    localparam int CLK_PERIOD     = 40;
    localparam int TIMEOUT_CYCLES = 4000;

    logic      clk;
    logic      reset;
    logic      in_valid;
    logic      allowin;
    word_t     in_pc;
    word_t     in_imm;
    word_t     in_rj;
    word_t     in_rkd;
    alu_op_t   in_alu_op;
    logic      in_src1_is_pc;
    logic      in_src2_is_imm;
    logic      in_src2_is_4;
    reg_idx_t  in_dest;
    logic      in_gr_we;
    mem_op_t   in_mem_op;
    div_op_t   in_div_op;
    logic      in_div_signed;
    logic      ms_allowin;
    logic      out_valid;
    word_t     out_pc;
    word_t     out_result;
    reg_idx_t  out_dest;
    logic      out_gr_we;
    mem_op_t   out_mem_op;
    logic [1:0] out_addr_low;
    logic      fwd_valid;
    reg_idx_t  fwd_dest;
    word_t     fwd_result;
    logic      fwd_is_load;
    logic      data_sram_req;
    logic      data_sram_wr;
    wstrb_t    data_sram_wstrb;
    mem_size_t data_sram_size;
    word_t     data_sram_addr;
    word_t     data_sram_wdata;
    logic      data_sram_addr_ok;

    word_t rng_state = 32'h917e_2215;
    int    cycle_count = 0;
    int    departures = 0;

    exe_unit_top UUT (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout: tests did not finish within %0d cycles", TIMEOUT_CYCLES);
            stop_on_failure();
        end
    end

    // instructions handed to the memory stage
    always @(posedge clk) begin
        if (!reset && out_valid && ms_allowin) begin
            departures++;
        end
    end

    function automatic word_t xorshift32(word_t s);
        word_t x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic word_t next_rand();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    function automatic word_t alu_model(alu_op_t op, word_t a, word_t b);
        word_t r;
        r = '0;
        case (1'b1)
            op[ALU_ADD]:  r = a + b;
            op[ALU_SUB]:  r = a - b;
            op[ALU_SLT]:  r = {31'd0, $signed(a) < $signed(b)};
            op[ALU_SLTU]: r = {31'd0, a < b};
            op[ALU_AND]:  r = a & b;
            op[ALU_OR]:   r = a | b;
            op[ALU_NOR]:  r = ~(a | b);
            op[ALU_XOR]:  r = a ^ b;
            op[ALU_SLL]:  r = a << b[4:0];
            op[ALU_SRL]:  r = a >> b[4:0];
            op[ALU_SRA]:  r = word_t'($signed(a) >>> b[4:0]);
            op[ALU_LUI]:  r = b;
            default:      r = '0;
        endcase
        return r;
    endfunction

    // magnitudes first, signs applied afterwards
    function automatic word_t div_model(word_t a, word_t b, logic sgn, div_op_t op);
        word_t ua;
        word_t ub;
        word_t q;
        word_t r;
        if (b == '0) begin
            q = '1;
            r = a;
        end else begin
            ua = (sgn && a[31]) ? -a : a;
            ub = (sgn && b[31]) ? -b : b;
            q = ua / ub;
            r = ua % ub;
            if (sgn && (a[31] != b[31])) q = -q;
            if (sgn && a[31]) r = -r;
        end
        return (op == div_rem) ? r : q;
    endfunction

    task automatic stop_on_failure();
        $display("FAIL: see errors above");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic check_word(input word_t got, input word_t exp, input string what);
        if (got !== exp) begin
            $display("CHECK FAILED at %0t ns: %s got %h expected %h", $time, what, got, exp);
            stop_on_failure();
        end
    endtask

    task automatic check_reg(input reg_idx_t got, input reg_idx_t exp, input string what);
        if (got !== exp) begin
            $display("CHECK FAILED at %0t ns: %s got %0d expected %0d", $time, what, got, exp);
            stop_on_failure();
        end
    endtask

    task automatic check_strb(input wstrb_t got, input wstrb_t exp, input string what);
        if (got !== exp) begin
            $display("CHECK FAILED at %0t ns: %s got %b expected %b", $time, what, got, exp);
            stop_on_failure();
        end
    endtask

    task automatic check_size(input mem_size_t got, input mem_size_t exp, input string what);
        if (got !== exp) begin
            $display("CHECK FAILED at %0t ns: %s got %0d expected %0d", $time, what, got, exp);
            stop_on_failure();
        end
    endtask

    task automatic check_mem_op(input mem_op_t got, input mem_op_t exp, input string what);
        if (got !== exp) begin
            $display("CHECK FAILED at %0t ns: %s got %0d expected %0d", $time, what, got, exp);
            stop_on_failure();
        end
    endtask

    task automatic check_bit(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            $display("CHECK FAILED at %0t ns: %s got %b expected %b", $time, what, got, exp);
            stop_on_failure();
        end
    endtask

    task automatic clear_inputs();
        in_valid          = 1'b0;
        in_pc             = '0;
        in_imm            = '0;
        in_rj             = '0;
        in_rkd            = '0;
        in_alu_op         = '0;
        in_src1_is_pc     = 1'b0;
        in_src2_is_imm    = 1'b0;
        in_src2_is_4      = 1'b0;
        in_dest           = '0;
        in_gr_we          = 1'b0;
        in_mem_op         = mem_none;
        in_div_op         = div_none;
        in_div_signed     = 1'b0;
        ms_allowin        = 1'b1;
        data_sram_addr_ok = 1'b1;
    endtask

    // called on a falling edge with the stage empty
    task automatic capture();
        check_bit(allowin, 1'b1, "allowin before capture");
        in_valid = 1'b1;
        @(posedge clk);
        @(negedge clk);
        in_valid = 1'b0;
    endtask

    task automatic wait_out_valid(output int cycles);
        cycles = 1;
        while (!out_valid) begin
            @(negedge clk);
            cycles++;
        end
    endtask

    task automatic test_alu_ops();
        word_t s1;
        word_t s2;
        word_t exp;
        int    lat;
        for (int bit_i = 0; bit_i < 12; bit_i++) begin
            for (int sel = 0; sel < 6; sel++) begin
                clear_inputs();
                in_alu_op      = alu_op_t'(1 << bit_i);
                in_pc          = next_rand();
                in_rj          = next_rand();
                in_rkd         = next_rand();
                in_imm         = next_rand();
                in_src1_is_pc  = sel[0];
                in_src2_is_imm = (sel / 2 == 1);
                in_src2_is_4   = (sel / 2 == 2);
                in_dest        = reg_idx_t'(next_rand());
                in_gr_we       = ((bit_i + sel) % 2 == 0);
                s1  = in_src1_is_pc ? in_pc : in_rj;
                s2  = in_src2_is_4 ? 32'd4 : (in_src2_is_imm ? in_imm : in_rkd);
                exp = alu_model(in_alu_op, s1, s2);
                capture();
                wait_out_valid(lat);
                check_word(word_t'(lat), 32'd1, "ALU latency");
                check_word(out_result, exp, "ALU result");
                check_word(out_pc, in_pc, "ALU pc");
                check_reg(out_dest, in_dest, "ALU dest");
                check_bit(out_gr_we, in_gr_we, "ALU gr_we");
                @(negedge clk);
            end
        end
    endtask

    task automatic run_divide(input word_t a, input word_t b, input logic sgn,
                              input div_op_t op);
        int lat;
        clear_inputs();
        in_div_op     = op;
        in_div_signed = sgn;
        in_rj         = a;
        in_rkd        = b;
        in_dest       = reg_idx_t'(next_rand());
        in_gr_we      = 1'b1;
        capture();
        wait_out_valid(lat);
        check_word(word_t'(lat), word_t'(DIV_STEPS + 2), "divide latency");
        check_word(out_result, div_model(a, b, sgn, op), "divide result");
        check_reg(out_dest, in_dest, "divide dest");
        @(negedge clk);
    endtask

    task automatic test_division();
        logic    sgn;
        div_op_t op;
        for (int k = 0; k < 4; k++) begin
            sgn = k[0];
            op  = k[1] ? div_rem : div_quot;
            for (int n = 0; n < 12; n++) begin
                run_divide(next_rand(), next_rand() >> (2 * n), sgn, op);
            end
            // mixed signs and a zero divisor
            run_divide(32'hffff_ff9c, 32'd7, sgn, op);
            run_divide(32'd100, 32'hffff_fff9, sgn, op);
            run_divide(next_rand(), 32'd0, sgn, op);
        end
    endtask

    task automatic test_stores();
        mem_op_t   kinds [3];
        word_t     base;
        word_t     data;
        wstrb_t    strb;
        word_t     wdata;
        mem_size_t size;
        kinds = '{st_b, st_h, st_w};
        for (int k = 0; k < 3; k++) begin
            for (int off = 0; off < 4; off++) begin
                clear_inputs();
                base           = next_rand() & 32'hffff_fffc;
                data           = next_rand();
                in_alu_op      = alu_op_t'(1 << ALU_ADD);
                in_rj          = base;
                in_imm         = word_t'(off);
                in_src2_is_imm = 1'b1;
                in_rkd         = data;
                in_mem_op      = kinds[k];
                case (kinds[k])
                    st_b: begin
                        strb  = wstrb_t'(1 << off);
                        wdata = {4{data[7:0]}};
                        size  = SIZE_BYTE;
                    end
                    st_h: begin
                        strb  = (off == 0) ? 4'b0011 : ((off == 2) ? 4'b1100 : 4'b0000);
                        wdata = {2{data[15:0]}};
                        size  = SIZE_HALF;
                    end
                    default: begin
                        strb  = 4'b1111;
                        wdata = data;
                        size  = SIZE_WORD;
                    end
                endcase
                capture();
                check_bit(data_sram_req, 1'b1, "store req");
                check_strb(data_sram_wstrb, strb, "store strobe");
                check_bit(data_sram_wr, |strb, "store wr");
                check_word(data_sram_wdata, wdata, "store wdata");
                check_size(data_sram_size, size, "store size");
                check_word(data_sram_addr, base + word_t'(off), "store addr");
                check_word(word_t'(out_addr_low), word_t'(off), "store addr low");
                check_mem_op(out_mem_op, kinds[k], "store mem_op");
                check_bit(out_valid, 1'b1, "store out_valid");
                @(negedge clk);
            end
        end
    endtask

    task automatic test_request_handshake();
        word_t addr_exp;
        int    left_before;
        clear_inputs();
        data_sram_addr_ok = 1'b0;
        in_alu_op         = alu_op_t'(1 << ALU_ADD);
        in_rj             = next_rand();
        in_imm            = next_rand();
        in_src2_is_imm    = 1'b1;
        in_mem_op         = ld_w;
        in_gr_we          = 1'b1;
        addr_exp          = in_rj + in_imm;
        capture();
        left_before = departures;
        repeat (5) begin
            check_bit(data_sram_req, 1'b1, "req held without addr_ok");
            check_bit(out_valid, 1'b0, "out_valid before addr_ok");
            check_bit(data_sram_wr, 1'b0, "load wr");
            check_word(data_sram_addr, addr_exp, "load addr");
            check_size(data_sram_size, SIZE_WORD, "load size");
            @(negedge clk);
        end
        data_sram_addr_ok = 1'b1;
        #1;
        check_bit(out_valid, 1'b1, "out_valid with addr_ok");
        check_bit(data_sram_req, 1'b1, "req with addr_ok");
        @(negedge clk);
        check_bit(out_valid, 1'b0, "out_valid after accept");
        check_word(word_t'(departures - left_before), 32'd1, "load departures");
    endtask

    task automatic test_back_pressure();
        word_t held;
        int    left_before;
        clear_inputs();
        ms_allowin = 1'b0;
        in_alu_op  = alu_op_t'(1 << ALU_XOR);
        in_rj      = next_rand();
        in_rkd     = next_rand();
        in_dest    = 5'd9;
        in_gr_we   = 1'b1;
        held       = in_rj ^ in_rkd;
        capture();
        left_before = departures;
        // a second instruction waits in decode
        in_valid = 1'b1;
        in_rj    = next_rand();
        repeat (6) begin
            check_bit(out_valid, 1'b1, "held out_valid");
            check_bit(allowin, 1'b0, "allowin under back-pressure");
            check_word(out_result, held, "held out_result");
            check_bit(data_sram_req, 1'b0, "req under back-pressure");
            @(negedge clk);
        end
        in_valid   = 1'b0;
        ms_allowin = 1'b1;
        repeat (3) @(negedge clk);
        check_word(word_t'(departures - left_before), 32'd1, "ALU departures");

        clear_inputs();
        ms_allowin = 1'b0;
        in_alu_op  = alu_op_t'(1 << ALU_ADD);
        in_rj      = next_rand() & 32'hffff_fffc;
        in_rkd     = next_rand();
        in_mem_op  = st_w;
        capture();
        left_before = departures;
        repeat (3) begin
            check_bit(data_sram_req, 1'b0, "store req under back-pressure");
            check_bit(out_valid, 1'b0, "store out_valid under back-pressure");
            check_bit(allowin, 1'b0, "store allowin under back-pressure");
            @(negedge clk);
        end
        ms_allowin = 1'b1;
        #1;
        check_bit(data_sram_req, 1'b1, "store req after release");
        @(negedge clk);
        check_word(word_t'(departures - left_before), 32'd1, "store departures");
    endtask

    task automatic test_forwarding();
        word_t sum;
        logic  is_load;
        int    left_before;
        for (int k = 0; k <= 8; k++) begin
            clear_inputs();
            ms_allowin     = 1'b0;
            in_mem_op      = mem_op_t'(k);
            in_alu_op      = alu_op_t'(1 << ALU_ADD);
            in_rj          = next_rand();
            in_imm         = next_rand();
            in_src2_is_imm = 1'b1;
            in_dest        = reg_idx_t'(k + 3);
            in_gr_we       = (k % 3 != 2);
            sum            = in_rj + in_imm;
            // ld_b through ld_w
            is_load        = (k >= 1) && (k <= 5);
            capture();
            left_before = departures;
            repeat (3) begin
                check_bit(fwd_valid, in_gr_we, "fwd_valid");
                check_reg(fwd_dest, in_dest, "fwd_dest");
                check_word(fwd_result, sum, "fwd_result");
                check_bit(fwd_is_load, is_load, "fwd_is_load");
                @(negedge clk);
            end
            ms_allowin = 1'b1;
            @(negedge clk);
            check_word(word_t'(departures - left_before), 32'd1, "forwarded departures");
        end
    endtask

    initial begin
        clear_inputs();
        reset = 1'b1;
        repeat (2) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        check_bit(out_valid, 1'b0, "out_valid after reset");
        check_bit(fwd_valid, 1'b0, "fwd_valid after reset");
        check_bit(data_sram_req, 1'b0, "req after reset");
        check_bit(data_sram_wr, 1'b0, "wr after reset");
        check_bit(UUT.div_bus.done, 1'b0, "divider done after reset");

        test_alu_ops();
        test_division();
        test_stores();
        test_request_handshake();
        test_back_pressure();
        test_forwarding();

        $display("PASS: all tests");
        $finish;
    end

endmodule
